// File: filelist.f
+incdir+hdl
hdl/engine_pkg.sv
hdl/merge_cfg_pkg.sv
hdl/fifo_if.sv
hdl/sync_fifo.sv
hdl/setup_filter.sv
hdl/merge_config_assembler.sv
hdl/merge_data_configure.sv
verif/tb_merge_data_configure.sv

// File: hdl/engine_pkg.sv
// --------------------------------------
// Engine response types
// Buffer classes and the memory response
// packet seen by the merge setup path
// --------------------------------------

`include "merge_consts.svh"

package engine_pkg;

    // --------------------------------------
    // Buffer class of a response
    // --------------------------------------
    typedef enum logic [2:0] {
        buf_invalid      = 3'd0,
        buf_cu_setup     = 3'd1,
        buf_engine_setup = 3'd2,
        buf_vertex_data  = 3'd3,
        buf_edge_data    = 3'd4,
        buf_aux_data     = 3'd5
    } buffer_class_t;

    // --------------------------------------
    // Response packet
    // --------------------------------------
    // Only the fields the merge setup path reads are kept
    typedef struct packed {
        buffer_class_t                   buffer;
        logic [`merge_offset_width-1:0]  offset;
        logic [`merge_shift_width-1:0]   shift;
        logic [`merge_data_width-1:0]    data;
    } response_packet_t;

endpackage : engine_pkg

// File: hdl/fifo_if.sv
// --------------------------------------
// FIFO bus
// Write side, read side and the storage
// view taken by the FIFO itself
// --------------------------------------

interface fifo_if #(
    parameter type elem_t = logic
) ();

    // Write side
    logic  wr_en;
    elem_t din;
    logic  full;
    logic  prog_full;

    // Read side
    logic  rd_en;
    elem_t dout;
    logic  valid;
    logic  empty;

    modport producer (
        output wr_en, din,
        input  full, prog_full
    );

    modport consumer (
        output rd_en,
        input  dout, valid, empty
    );

    modport storage (
        input  wr_en, din, rd_en,
        output dout, valid, empty, full, prog_full
    );

endinterface : fifo_if

// File: hdl/merge_cfg_pkg.sv
// --------------------------------------
// Merge configuration types
// Parameter word views and the finished
// configuration handed downstream
// --------------------------------------

`include "merge_consts.svh"

package merge_cfg_pkg;

    // Type code split into operation and argument
    typedef struct packed {
        logic [`merge_num_fields/2-1:0]                   op;
        logic [`merge_num_fields-`merge_num_fields/2-1:0] arg;
    } merge_type_view_t;

    // One setup word, read as a field mask or as a type code
    typedef union packed {
        logic [`merge_num_fields-1:0] field_mask;
        merge_type_view_t             type_code;
    } merge_param_u;

    // --------------------------------------
    // Finished configuration
    // --------------------------------------
    typedef struct packed {
        logic [`merge_num_fields-1:0] merge_mask;
        logic [`merge_num_fields-1:0] merge_type;
    } merge_config_t;

endpackage : merge_cfg_pkg

// File: hdl/merge_config_assembler.sv
// --------------------------------------
// Merge configuration assembler
// Collects a window of setup words and
// writes one finished configuration
// --------------------------------------

`include "merge_consts.svh"

module merge_config_assembler
    import engine_pkg::*;
    import merge_cfg_pkg::*;
#(
    parameter int unsigned seq_base = 0
) (
    input  logic     ap_clk,
    input  logic     areset_csr_index_generator,
    fifo_if.consumer resp_bus,
    fifo_if.producer cfg_bus
);

    localparam int idx_width = $clog2(`merge_seq_width);
    localparam logic [`merge_offset_width-1:0] seq_lo = seq_base[`merge_offset_width-1:0];

    response_packet_t               word;
    logic [`merge_offset_width-1:0] rel_seq;
    logic [idx_width-1:0]           idx;
    merge_param_u                   param_word;

    logic [`merge_seq_width-1:0]    done_bits;
    logic [`merge_seq_width-1:0]    done_next;
    logic                           cfg_done;

    logic [`merge_num_fields-1:0]   merge_mask;
    logic [`merge_num_fields-1:0]   merge_type;
    merge_config_t                  cfg_reg;
    logic                           cfg_wr;

    // --------------------------------------
    // Popped word decode
    // --------------------------------------
    assign word    = resp_bus.dout;
    assign rel_seq = (word.offset >> word.shift) - seq_lo;
    assign idx     = rel_seq[idx_width-1:0];

    // Low bits of data field 0 carry the parameter
    assign param_word.field_mask = word.data[`merge_num_fields-1:0];

    assign cfg_done = &done_bits;

    // Hold off while a config completes or downstream is backing up
    assign resp_bus.rd_en = ~resp_bus.empty & ~cfg_done & ~cfg_bus.prog_full;

    // --------------------------------------
    // Done bits
    // --------------------------------------
    always_comb begin
        done_next = cfg_done ? '0 : done_bits;
        if (resp_bus.valid) begin
            done_next[idx] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            done_bits <= '0;
            cfg_wr    <= 1'b0;
        end else begin
            done_bits <= done_next;
            cfg_wr    <= cfg_done;
        end
    end

    // Mask and type, a later word wins
    always_ff @(posedge ap_clk) begin
        if (resp_bus.valid && idx == idx_width'(0)) begin
            merge_mask <= param_word.field_mask;
        end
        if (resp_bus.valid && idx == idx_width'(1)) begin
            merge_type <= param_word.type_code;
        end
    end

    // Snapshot taken while the window is complete
    always_ff @(posedge ap_clk) begin
        if (cfg_done) begin
            cfg_reg.merge_mask <= merge_mask;
            cfg_reg.merge_type <= merge_type;
        end
    end

    // --------------------------------------
    // Config FIFO write
    // --------------------------------------
    assign cfg_bus.wr_en = cfg_wr;
    assign cfg_bus.din   = cfg_reg;

    // Filter upstream only lets window members through
    a_popped_in_window : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        resp_bus.valid |-> (rel_seq < `merge_seq_width)
    );

    // prog_full stall must keep the config FIFO from overflowing
    a_cfg_not_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        cfg_bus.wr_en |-> !cfg_bus.full
    );

endmodule : merge_config_assembler

// File: hdl/merge_consts.svh
// --------------------------------------
// Merge setup constants
// Widths, window size and FIFO sizing
// shared by the merge setup collector
// --------------------------------------

`ifndef merge_consts_svh
`define merge_consts_svh

// Sequence window of one merge engine
`define merge_seq_width    16

// Address and response field widths
`define merge_offset_width 16
`define merge_shift_width  4
`define merge_data_width   32

// Fields covered by a merge mask
`define merge_num_fields   4

// FIFO sizing
`define merge_fifo_depth   32
`define merge_prog_thresh  16

`endif

// File: hdl/merge_data_configure.sv
// --------------------------------------
// Merge data configure
// Top of the setup collector: filter,
// response FIFO, assembler, config FIFO
// and the registered output stage
// --------------------------------------

`include "merge_consts.svh"

module merge_data_configure
    import engine_pkg::*;
    import merge_cfg_pkg::*;
#(
    parameter int unsigned seq_base = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  logic                           response_valid,
    input  buffer_class_t                  response_buffer,
    input  logic [`merge_offset_width-1:0] response_offset,
    input  logic [`merge_shift_width-1:0]  response_shift,
    input  logic [`merge_data_width-1:0]   response_data,
    output logic                           response_prog_full,
    input  logic                           config_rd_en,
    output logic                           config_empty,
    output logic                           config_valid,
    output logic [`merge_num_fields-1:0]   config_merge_mask,
    output logic [`merge_num_fields-1:0]   config_merge_type
);

    response_packet_t response_packet;
    logic             config_rd_en_reg;

    fifo_if #(.elem_t(response_packet_t)) resp_fifo_bus ();
    fifo_if #(.elem_t(merge_config_t))    cfg_fifo_bus ();

    // Gather the plain response ports into one packet
    assign response_packet.buffer = response_buffer;
    assign response_packet.offset = response_offset;
    assign response_packet.shift  = response_shift;
    assign response_packet.data   = response_data;

    // --------------------------------------
    // Response path
    // --------------------------------------
    setup_filter #(
        .seq_base(seq_base)
    ) i_setup_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .in_valid                  (response_valid),
        .in_packet                 (response_packet),
        .resp_bus                  (resp_fifo_bus)
    );

    sync_fifo #(
        .depth      (`merge_fifo_depth),
        .prog_thresh(`merge_prog_thresh)
    ) i_resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .bus                       (resp_fifo_bus)
    );

    assign response_prog_full = resp_fifo_bus.prog_full;

    merge_config_assembler #(
        .seq_base(seq_base)
    ) i_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_bus                  (resp_fifo_bus),
        .cfg_bus                   (cfg_fifo_bus)
    );

    // --------------------------------------
    // Config path
    // --------------------------------------
    sync_fifo #(
        .depth      (`merge_fifo_depth),
        .prog_thresh(`merge_prog_thresh)
    ) i_cfg_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .bus                       (cfg_fifo_bus)
    );

    // Consumer strobe registered once, then gated by empty
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            config_rd_en_reg <= 1'b0;
            config_valid     <= 1'b0;
        end else begin
            config_rd_en_reg <= config_rd_en;
            config_valid     <= cfg_fifo_bus.valid;
        end
    end

    assign cfg_fifo_bus.rd_en = config_rd_en_reg & ~cfg_fifo_bus.empty;
    assign config_empty       = cfg_fifo_bus.empty;

    // Output payload register
    always_ff @(posedge ap_clk) begin
        config_merge_mask <= cfg_fifo_bus.dout.merge_mask;
        config_merge_type <= cfg_fifo_bus.dout.merge_type;
    end

endmodule : merge_data_configure

// File: hdl/setup_filter.sv
// --------------------------------------
// Setup filter
// Registers memory responses and pushes
// in-window setup words to the FIFO
// --------------------------------------

`include "merge_consts.svh"

module setup_filter
    import engine_pkg::*;
#(
    parameter int unsigned seq_base = 0
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             in_valid,
    input  response_packet_t in_packet,
    fifo_if.producer         resp_bus
);

    logic                           valid_reg;
    response_packet_t               packet_reg;
    logic [`merge_offset_width-1:0] seq;
    logic                           is_setup;
    logic                           in_window;

    // --------------------------------------
    // Input register
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_reg <= in_packet;
    end

    // Sequence number of the registered word
    assign seq = packet_reg.offset >> packet_reg.shift;

    assign is_setup = (packet_reg.buffer == buf_cu_setup) ||
                      (packet_reg.buffer == buf_engine_setup);

    // Window is seq_base up to seq_base plus sixteen, exclusive
    assign in_window = (seq >= seq_base) && (seq < seq_base + `merge_seq_width);

    // --------------------------------------
    // Push into the response FIFO
    // --------------------------------------
    assign resp_bus.wr_en = valid_reg & is_setup & in_window;
    assign resp_bus.din   = packet_reg;

endmodule : setup_filter

// File: hdl/sync_fifo.sv
// --------------------------------------
// Synchronous FIFO
// Circular buffer with registered read
// data, one-cycle valid and prog_full
// --------------------------------------

`include "merge_consts.svh"

module sync_fifo #(
    parameter int depth       = `merge_fifo_depth,
    parameter int prog_thresh = `merge_prog_thresh
) (
    input logic   ap_clk,
    input logic   areset_csr_index_generator,
    fifo_if.storage bus
);

    localparam int width     = $bits(bus.din);
    localparam int ptr_width = $clog2(depth);
    localparam int cnt_width = $clog2(depth + 1);

    logic [width-1:0]     mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic                 do_wr;
    logic                 do_rd;

    assign do_wr = bus.wr_en & ~bus.full;
    assign do_rd = bus.rd_en & ~bus.empty;

    // Status straight from the fill count
    assign bus.full      = (count == cnt_width'(depth));
    assign bus.empty     = (count == '0);
    assign bus.prog_full = (count >= cnt_width'(prog_thresh));

    // --------------------------------------
    // Pointers and fill level
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= bus.din;
        end
        if (do_rd) begin
            bus.dout <= mem[rd_ptr];
        end
    end

    // Producer and consumer must respect the flags
    a_no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        bus.wr_en |-> !bus.full
    );

    a_no_read_when_empty : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        bus.rd_en |-> !bus.empty
    );

endmodule : sync_fifo

// File: run_sim.sh
#!/bin/sh
# Build and run the merge setup testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_merge_data_configure -Mdir obj_dir > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

# A crash or an assertion stop counts as a failure as well
./obj_dir/Vtb_merge_data_configure > sim.log 2>&1 \
    || echo "*** FAILED ***" >> sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// File: verif/tb_merge_data_configure.sv
// ----------------------------------------
// Merge data configure testbench
// Random setup windows, reference model
// and assertion based output checks
// ----------------------------------------

`include "merge_consts.svh"

module tb_merge_data_configure
    import engine_pkg::*;
();

    localparam int seq_base    = 32;
    // Reset, ten windows of at most 80 cycles, five drains of 100, margin
    localparam int cycle_limit = 16 + 10 * 80 + 5 * 100 + 400;

    logic                           ap_clk;
    logic                           areset_csr_index_generator;
    logic                           response_valid;
    buffer_class_t                  response_buffer;
    logic [`merge_offset_width-1:0] response_offset;
    logic [`merge_shift_width-1:0]  response_shift;
    logic [`merge_data_width-1:0]   response_data;
    logic                           response_prog_full;
    logic                           config_rd_en;
    logic                           config_empty;
    logic                           config_valid;
    logic [`merge_num_fields-1:0]   config_merge_mask;
    logic [`merge_num_fields-1:0]   config_merge_type;

    // Reference model state
    int                           idx_q[$];
    logic [`merge_data_width-1:0] dat_q[$];
    logic [`merge_num_fields-1:0] win_mask;
    logic [`merge_num_fields-1:0] win_type;
    logic [`merge_num_fields-1:0] exp_mask [64];
    logic [`merge_num_fields-1:0] exp_type [64];
    logic [`merge_num_fields-1:0] head_mask;
    logic [`merge_num_fields-1:0] head_type;
    int                           exp_wr;
    int                           exp_rd;
    logic                         expect_idle;
    logic                         hold_out;
    string                        test_name;
    int                           fail_count;
    int                           test_start_fails;
    int                           tests_failed;
    int                           cycle_count;

    initial ap_clk = 1'b0;
    always #10 ap_clk = ~ap_clk;

    merge_data_configure #(
        .seq_base(seq_base)
    ) i_dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_buffer           (response_buffer),
        .response_offset           (response_offset),
        .response_shift            (response_shift),
        .response_data             (response_data),
        .response_prog_full        (response_prog_full),
        .config_rd_en              (config_rd_en),
        .config_empty              (config_empty),
        .config_valid              (config_valid),
        .config_merge_mask         (config_merge_mask),
        .config_merge_type         (config_merge_type)
    );

    // ----------------------------------------
    // Output checks
    // ----------------------------------------
    assign head_mask = exp_mask[exp_rd % 64];
    assign head_type = exp_type[exp_rd % 64];

    always @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            exp_rd <= 0;
        end else if (config_valid) begin
            exp_rd <= exp_rd + 1;
        end
    end

    a_config_predicted : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        config_valid |-> (exp_rd < exp_wr)
    ) else begin
        $display("test %s: configuration delivered that was never predicted", test_name);
        fail_count++;
    end

    a_config_value : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        (config_valid && (exp_rd < exp_wr)) |->
            (config_merge_mask == head_mask) && (config_merge_type == head_type)
    ) else begin
        $display("error: test %s expected mask %h type %h, actual mask %h type %h", test_name,
                 $sampled(head_mask), $sampled(head_type),
                 $sampled(config_merge_mask), $sampled(config_merge_type));
        fail_count++;
    end

    a_outputs_idle : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        expect_idle |-> (!config_valid && !response_prog_full && config_empty)
    ) else begin
        $display("test %s: outputs left the idle state without a full window", test_name);
        fail_count++;
    end

    a_output_held : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        hold_out |-> !config_valid
    ) else begin
        $display("test %s: configuration delivered while config_rd_en was low", test_name);
        fail_count++;
    end

    // Run limit
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic drive_word(input logic [2:0] cls, input int seq, input int sh,
                              input logic [`merge_data_width-1:0] data);
        logic [`merge_offset_width-1:0] off;
        // Bits below the shift are dropped by the DUT, so fill them randomly
        off = 16'((seq << sh) | ($urandom & ((1 << sh) - 1)));
        @(negedge ap_clk);
        while (response_prog_full) begin
            @(posedge ap_clk);
            response_valid <= 1'b0;
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        response_valid  <= 1'b1;
        response_buffer <= buffer_class_t'(cls);
        response_offset <= off;
        response_shift  <= 4'(sh);
        response_data   <= data;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ap_clk);
            response_valid <= 1'b0;
        end
    endtask

    // Wrong class, below the window or above it
    task automatic inject_stray_word();
        int          kind;
        int          seq;
        int          target;
        logic [2:0]  cls;
        kind   = $urandom % 3;
        // Each stray aliases the index still missing from the window
        target = idx_q[idx_q.size() - 1];
        cls    = ($urandom % 2) ? 3'd1 : 3'd2;
        if (kind == 0) begin
            seq = seq_base + target;
            cls = ($urandom % 2) ? 3'd0 : 3'(3 + $urandom % 3);
        end else if (kind == 1) begin
            seq = target + 16 * ($urandom % 2);
        end else begin
            seq = seq_base + 16 + target + 16 * ($urandom % 12);
        end
        drive_word(cls, seq, $urandom % 5, $urandom);
    endtask

    task automatic build_window();
        int j;
        int tmp;
        int pos;
        idx_q.delete();
        dat_q.delete();
        for (int i = 0; i < 16; i++) begin
            idx_q.push_back(i);
            dat_q.push_back($urandom);
        end
        for (int i = 15; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = idx_q[i];
            idx_q[i] = idx_q[j];
            idx_q[j] = tmp;
        end
        // Rewrites of index 0 and 1, kept ahead of the closing word
        for (int r = 0; r < 2; r++) begin
            if (idx_q[idx_q.size() - 1] != r) begin
                pos = $urandom % idx_q.size();
                idx_q.insert(pos, r);
                dat_q.insert(pos, $urandom);
            end
        end
        foreach (idx_q[k]) begin
            if (idx_q[k] == 0) begin
                win_mask = dat_q[k][`merge_num_fields-1:0];
            end
            if (idx_q[k] == 1) begin
                win_type = dat_q[k][`merge_num_fields-1:0];
            end
        end
    endtask

    task automatic play_window(input int first, input int last, input bit shifted,
                               input bit strays);
        for (int k = first; k <= last; k++) begin
            drive_word(($urandom % 2) ? 3'd1 : 3'd2, seq_base + idx_q[k],
                       shifted ? int'(1 + $urandom % 4) : 0, dat_q[k]);
            if (strays) begin
                repeat ($urandom % 3) inject_stray_word();
            end
        end
        idle_cycles(1);
    endtask

    task automatic push_expected();
        exp_mask[exp_wr % 64] = win_mask;
        exp_type[exp_wr % 64] = win_type;
        exp_wr++;
    endtask

    task automatic wait_drained();
        @(negedge ap_clk);
        while (exp_rd != exp_wr) begin
            @(negedge ap_clk);
        end
        idle_cycles(4);
    endtask

    task automatic start_test(input string name);
        test_name        = name;
        test_start_fails = fail_count;
    endtask

    task automatic report_test();
        if (fail_count == test_start_fails) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, fail_count - test_start_fails);
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(32'hf6ec8481));
        areset_csr_index_generator = 1'b1;
        response_valid  = 1'b0;
        response_buffer = buf_invalid;
        response_offset = '0;
        response_shift  = '0;
        response_data   = '0;
        config_rd_en    = 1'b0;
        expect_idle     = 1'b0;
        hold_out        = 1'b0;
        exp_wr          = 0;
        fail_count      = 0;
        tests_failed    = 0;
        cycle_count     = 0;
        test_name       = "reset";
        repeat (16) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;

        start_test("idle_after_reset");
        expect_idle  <= 1'b1;
        config_rd_en <= 1'b1;
        idle_cycles(20);
        expect_idle <= 1'b0;
        report_test();

        start_test("random_order");
        repeat (3) begin
            build_window();
            push_expected();
            play_window(0, idx_q.size() - 1, $urandom % 2, 1'b0);
        end
        wait_drained();
        report_test();

        // Fifteen indices plus strays, then the closing word
        start_test("out_of_window");
        build_window();
        repeat (3) inject_stray_word();
        play_window(0, idx_q.size() - 2, $urandom % 2, 1'b1);
        expect_idle <= 1'b1;
        idle_cycles(40);
        expect_idle <= 1'b0;
        push_expected();
        play_window(idx_q.size() - 1, idx_q.size() - 1, 1'b0, 1'b0);
        wait_drained();
        report_test();

        start_test("shift_invariance");
        build_window();
        push_expected();
        play_window(0, idx_q.size() - 1, 1'b0, 1'b0);
        push_expected();
        play_window(0, idx_q.size() - 1, 1'b1, 1'b0);
        wait_drained();
        report_test();

        start_test("held_output");
        config_rd_en <= 1'b0;
        idle_cycles(4);
        hold_out <= 1'b1;
        repeat (4) begin
            build_window();
            push_expected();
            play_window(0, idx_q.size() - 1, $urandom % 2, 1'b0);
        end
        idle_cycles(40);
        hold_out     <= 1'b0;
        config_rd_en <= 1'b1;
        wait_drained();
        report_test();

        $display("tests run 5, passed %0d, failed %0d, check errors %0d",
                 5 - tests_failed, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_merge_data_configure
